// File: source/iq_pkg.sv
`default_nettype none

package iq_pkg;

  localparam int PAYLOAD_W = 16;
  localparam int SEQ_W = 5;
  localparam int COUNT_W = 4;
  localparam int IQ_DEPTH_DEFAULT = 8;

  // instruction body, never looked at inside the subsystem
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // dispatch order number, compared by the sign of a difference
  typedef logic [SEQ_W-1:0] seq_t;

  typedef logic [COUNT_W-1:0] count_t;  // free entries of one queue, 0 up to the depth

  typedef enum logic {
    ALU_CLASS = 1'b0,
    MEM_CLASS = 1'b1
  } iq_class_e;

endpackage

`default_nettype wire

// File: source/issue_queue.sv
`default_nettype none

module issue_queue
  import iq_pkg::*;
#(
  parameter int DEPTH = IQ_DEPTH_DEFAULT
) (
  input  wire      clk,
  input  wire      rst,
  input  wire      flush,

  input  wire      push0,
  input  wire      push1,
  input  payload_t push_payload0,
  input  payload_t push_payload1,
  input  seq_t     push_seq0,
  input  seq_t     push_seq1,

  input  wire      pop0,
  input  wire      pop1,

  output logic     head_valid0,
  output logic     head_valid1,
  output payload_t head_payload0,
  output payload_t head_payload1,
  output seq_t     head_seq0,
  output seq_t     head_seq1,

  output count_t   free_count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  payload_t payload_mem [DEPTH];
  seq_t     seq_mem     [DEPTH];
  logic [DEPTH-1:0] slot_valid;

  ptr_t rd_ptr;
  ptr_t wr_ptr;
  ptr_t rd_ptr1;
  ptr_t wr_ptr1;

  logic [1:0] push_cnt;
  logic [1:0] pop_cnt;

  // pointer step with wrap at DEPTH, which need not be a power of two
  function automatic ptr_t ptr_add(ptr_t ptr, int unsigned step);
    int unsigned sum;
    sum = int'(ptr) + step;
    if (sum >= DEPTH) begin
      sum = sum - DEPTH;
    end
    return ptr_t'(sum);
  endfunction

  assign rd_ptr1 = ptr_add(rd_ptr, 1);
  assign wr_ptr1 = ptr_add(wr_ptr, 1);

  assign push_cnt = {1'b0, push0} + {1'b0, push1};  // push1 only comes with push0
  assign pop_cnt  = {1'b0, pop0} + {1'b0, pop1};

  // live slots are contiguous from rd_ptr, so slot 1 can only be valid behind slot 0
  assign head_valid0   = slot_valid[rd_ptr];
  assign head_valid1   = slot_valid[rd_ptr1];
  assign head_payload0 = payload_mem[rd_ptr];
  assign head_payload1 = payload_mem[rd_ptr1];
  assign head_seq0     = seq_mem[rd_ptr];
  assign head_seq1     = seq_mem[rd_ptr1];

  always_comb begin
    free_count = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (!slot_valid[i]) begin
        free_count = free_count + count_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_valid <= '0;
    end else begin
      // a push never lands on a slot that is being popped, the router respects free_count
      if (push0) begin
        slot_valid[wr_ptr] <= 1'b1;
      end
      if (push1) begin
        slot_valid[wr_ptr1] <= 1'b1;
      end
      if (pop0) begin
        slot_valid[rd_ptr] <= 1'b0;
      end
      if (pop1) begin
        slot_valid[rd_ptr1] <= 1'b0;
      end
      wr_ptr <= ptr_add(wr_ptr, push_cnt);
      rd_ptr <= ptr_add(rd_ptr, pop_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (push0) begin
      payload_mem[wr_ptr] <= push_payload0;
      seq_mem[wr_ptr]     <= push_seq0;
    end
    if (push1) begin
      payload_mem[wr_ptr1] <= push_payload1;
      seq_mem[wr_ptr1]     <= push_seq1;
    end
  end

endmodule

`default_nettype wire

// File: source/dispatch_router.sv
`default_nettype none

module dispatch_router
  import iq_pkg::*;
#(
  parameter int DEPTH = IQ_DEPTH_DEFAULT
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       flush,

  input  wire       disp_valid0,
  input  wire       disp_valid1,
  input  iq_class_e disp_class0,
  input  iq_class_e disp_class1,
  input  payload_t  disp_payload0,
  input  payload_t  disp_payload1,

  input  count_t    alu_free,
  input  count_t    mem_free,

  output logic      disp_stall,

  output logic      alu_push0,
  output logic      alu_push1,
  output payload_t  alu_push_payload0,
  output payload_t  alu_push_payload1,
  output seq_t      alu_push_seq0,
  output seq_t      alu_push_seq1,

  output logic      mem_push0,
  output logic      mem_push1,
  output payload_t  mem_push_payload0,
  output payload_t  mem_push_payload1,
  output seq_t      mem_push_seq0,
  output seq_t      mem_push_seq1
);

  seq_t seq_cnt;
  seq_t seq0;
  seq_t seq1;

  logic [1:0] alu_need;
  logic [1:0] mem_need;
  logic [1:0] accept_cnt;
  logic       accept;
  logic       acc0;
  logic       acc1;
  logic       alu0;
  logic       alu1;
  logic       mem0;
  logic       mem1;

  // true when the queue's occupancy plus the new entries overflows DEPTH
  function automatic logic over_capacity(count_t free_n, logic [1:0] need);
    int unsigned used;
    used = DEPTH - int'(free_n);
    return (used + need) > DEPTH;
  endfunction

  assign alu_need = {1'b0, disp_valid0 && disp_class0 == ALU_CLASS}
                  + {1'b0, disp_valid1 && disp_class1 == ALU_CLASS};
  assign mem_need = {1'b0, disp_valid0 && disp_class0 == MEM_CLASS}
                  + {1'b0, disp_valid1 && disp_class1 == MEM_CLASS};

  assign disp_stall = over_capacity(alu_free, alu_need) || over_capacity(mem_free, mem_need);

  assign accept = !disp_stall && !flush;  // flush drops the pair
  assign acc0   = disp_valid0 && accept;
  assign acc1   = disp_valid1 && accept;

  assign alu0 = acc0 && disp_class0 == ALU_CLASS;
  assign alu1 = acc1 && disp_class1 == ALU_CLASS;
  assign mem0 = acc0 && disp_class0 == MEM_CLASS;
  assign mem1 = acc1 && disp_class1 == MEM_CLASS;

  assign seq0 = seq_cnt;
  assign seq1 = seq_cnt + seq_t'(acc0);  // consecutive only among accepted slots

  // the first instruction for a queue always takes port 0
  assign alu_push0         = alu0 || alu1;
  assign alu_push1         = alu0 && alu1;
  assign alu_push_payload0 = alu0 ? disp_payload0 : disp_payload1;
  assign alu_push_payload1 = disp_payload1;
  assign alu_push_seq0     = alu0 ? seq0 : seq1;
  assign alu_push_seq1     = seq1;

  assign mem_push0         = mem0 || mem1;
  assign mem_push1         = mem0 && mem1;
  assign mem_push_payload0 = mem0 ? disp_payload0 : disp_payload1;
  assign mem_push_payload1 = disp_payload1;
  assign mem_push_seq0     = mem0 ? seq0 : seq1;
  assign mem_push_seq1     = seq1;

  assign accept_cnt = {1'b0, acc0} + {1'b0, acc1};

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      seq_cnt <= '0;
    end else begin
      seq_cnt <= seq_cnt + seq_t'(accept_cnt);
    end
  end

endmodule

`default_nettype wire

// File: source/issue_select.sv
`default_nettype none

module issue_select
  import iq_pkg::*;
(
  input  wire       alu_hold,
  input  wire       mem_hold,

  input  wire       alu_head_valid0,
  input  wire       alu_head_valid1,
  input  payload_t  alu_head_payload0,
  input  payload_t  alu_head_payload1,
  input  seq_t      alu_head_seq0,
  input  seq_t      alu_head_seq1,

  input  wire       mem_head_valid0,
  input  wire       mem_head_valid1,
  input  payload_t  mem_head_payload0,
  input  payload_t  mem_head_payload1,
  input  seq_t      mem_head_seq0,
  input  seq_t      mem_head_seq1,

  output logic      alu_pop0,
  output logic      alu_pop1,
  output logic      mem_pop0,
  output logic      mem_pop1,

  output logic      issue_valid0,
  output logic      issue_valid1,
  output iq_class_e issue_class0,
  output iq_class_e issue_class1,
  output payload_t  issue_payload0,
  output payload_t  issue_payload1,
  output seq_t      issue_seq0,
  output seq_t      issue_seq1
);

  logic     alu_ok0;
  logic     alu_ok1;
  logic     mem_ok0;
  logic     mem_ok1;
  logic     pick0_alu;
  logic     pick0_mem;
  logic     pick1_alu;
  logic     pick1_mem;

  logic     cand_alu_valid;
  logic     cand_mem_valid;
  seq_t     cand_alu_seq;
  seq_t     cand_mem_seq;
  payload_t cand_alu_payload;
  payload_t cand_mem_payload;

  // a is older than b when a - b is negative, which survives counter wrap
  function automatic logic is_older(seq_t a, seq_t b);
    seq_t diff;
    diff = a - b;
    return diff[SEQ_W-1];
  endfunction

  assign alu_ok0 = alu_head_valid0 && !alu_hold;
  assign alu_ok1 = alu_head_valid1 && !alu_hold;
  assign mem_ok0 = mem_head_valid0 && !mem_hold;
  assign mem_ok1 = mem_head_valid1 && !mem_hold;

  assign pick0_alu = alu_ok0 && (!mem_ok0 || is_older(alu_head_seq0, mem_head_seq0));
  assign pick0_mem = mem_ok0 && !pick0_alu;

  // the queue that won slot 0 offers its second entry for slot 1
  assign cand_alu_valid   = pick0_alu ? alu_ok1 : alu_ok0;
  assign cand_alu_seq     = pick0_alu ? alu_head_seq1 : alu_head_seq0;
  assign cand_alu_payload = pick0_alu ? alu_head_payload1 : alu_head_payload0;
  assign cand_mem_valid   = pick0_mem ? mem_ok1 : mem_ok0;
  assign cand_mem_seq     = pick0_mem ? mem_head_seq1 : mem_head_seq0;
  assign cand_mem_payload = pick0_mem ? mem_head_payload1 : mem_head_payload0;

  assign pick1_alu = cand_alu_valid && (!cand_mem_valid || is_older(cand_alu_seq, cand_mem_seq));
  assign pick1_mem = cand_mem_valid && !pick1_alu;

  assign alu_pop0 = pick0_alu || pick1_alu;
  assign alu_pop1 = pick0_alu && pick1_alu;
  assign mem_pop0 = pick0_mem || pick1_mem;
  assign mem_pop1 = pick0_mem && pick1_mem;

  assign issue_valid0   = pick0_alu || pick0_mem;
  assign issue_class0   = pick0_alu ? ALU_CLASS : MEM_CLASS;
  assign issue_payload0 = pick0_alu ? alu_head_payload0 : mem_head_payload0;
  assign issue_seq0     = pick0_alu ? alu_head_seq0 : mem_head_seq0;

  assign issue_valid1   = pick1_alu || pick1_mem;  // both candidates are empty without slot 0
  assign issue_class1   = pick1_alu ? ALU_CLASS : MEM_CLASS;
  assign issue_payload1 = pick1_alu ? cand_alu_payload : cand_mem_payload;
  assign issue_seq1     = pick1_alu ? cand_alu_seq : cand_mem_seq;

endmodule

`default_nettype wire

// File: source/iq_top.sv
`default_nettype none

module iq_top
  import iq_pkg::*;
#(
  parameter int DEPTH = IQ_DEPTH_DEFAULT
) (
  input  wire       clk,
  input  wire       rst,
  input  wire       flush,

  input  wire       disp_valid0,
  input  wire       disp_valid1,
  input  iq_class_e disp_class0,
  input  iq_class_e disp_class1,
  input  payload_t  disp_payload0,
  input  payload_t  disp_payload1,
  output logic      disp_stall,

  input  wire       alu_hold,
  input  wire       mem_hold,

  output logic      issue_valid0,
  output logic      issue_valid1,
  output iq_class_e issue_class0,
  output iq_class_e issue_class1,
  output payload_t  issue_payload0,
  output payload_t  issue_payload1,
  output seq_t      issue_seq0,
  output seq_t      issue_seq1
);

  count_t   alu_free;
  count_t   mem_free;

  logic     alu_push0;
  logic     alu_push1;
  payload_t alu_push_payload0;
  payload_t alu_push_payload1;
  seq_t     alu_push_seq0;
  seq_t     alu_push_seq1;
  logic     mem_push0;
  logic     mem_push1;
  payload_t mem_push_payload0;
  payload_t mem_push_payload1;
  seq_t     mem_push_seq0;
  seq_t     mem_push_seq1;

  logic     alu_head_valid0;
  logic     alu_head_valid1;
  payload_t alu_head_payload0;
  payload_t alu_head_payload1;
  seq_t     alu_head_seq0;
  seq_t     alu_head_seq1;
  logic     mem_head_valid0;
  logic     mem_head_valid1;
  payload_t mem_head_payload0;
  payload_t mem_head_payload1;
  seq_t     mem_head_seq0;
  seq_t     mem_head_seq1;

  logic     alu_pop0;
  logic     alu_pop1;
  logic     mem_pop0;
  logic     mem_pop1;

  dispatch_router #(
    .DEPTH(DEPTH)
  ) dispatch_router_i (
    .clk              (clk),
    .rst              (rst),
    .flush            (flush),
    .disp_valid0      (disp_valid0),
    .disp_valid1      (disp_valid1),
    .disp_class0      (disp_class0),
    .disp_class1      (disp_class1),
    .disp_payload0    (disp_payload0),
    .disp_payload1    (disp_payload1),
    .alu_free         (alu_free),
    .mem_free         (mem_free),
    .disp_stall       (disp_stall),
    .alu_push0        (alu_push0),
    .alu_push1        (alu_push1),
    .alu_push_payload0(alu_push_payload0),
    .alu_push_payload1(alu_push_payload1),
    .alu_push_seq0    (alu_push_seq0),
    .alu_push_seq1    (alu_push_seq1),
    .mem_push0        (mem_push0),
    .mem_push1        (mem_push1),
    .mem_push_payload0(mem_push_payload0),
    .mem_push_payload1(mem_push_payload1),
    .mem_push_seq0    (mem_push_seq0),
    .mem_push_seq1    (mem_push_seq1)
  );

  issue_queue #(
    .DEPTH(DEPTH)
  ) alu_queue (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .push0        (alu_push0),
    .push1        (alu_push1),
    .push_payload0(alu_push_payload0),
    .push_payload1(alu_push_payload1),
    .push_seq0    (alu_push_seq0),
    .push_seq1    (alu_push_seq1),
    .pop0         (alu_pop0),
    .pop1         (alu_pop1),
    .head_valid0  (alu_head_valid0),
    .head_valid1  (alu_head_valid1),
    .head_payload0(alu_head_payload0),
    .head_payload1(alu_head_payload1),
    .head_seq0    (alu_head_seq0),
    .head_seq1    (alu_head_seq1),
    .free_count   (alu_free)
  );

  issue_queue #(
    .DEPTH(DEPTH)
  ) mem_queue (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .push0        (mem_push0),
    .push1        (mem_push1),
    .push_payload0(mem_push_payload0),
    .push_payload1(mem_push_payload1),
    .push_seq0    (mem_push_seq0),
    .push_seq1    (mem_push_seq1),
    .pop0         (mem_pop0),
    .pop1         (mem_pop1),
    .head_valid0  (mem_head_valid0),
    .head_valid1  (mem_head_valid1),
    .head_payload0(mem_head_payload0),
    .head_payload1(mem_head_payload1),
    .head_seq0    (mem_head_seq0),
    .head_seq1    (mem_head_seq1),
    .free_count   (mem_free)
  );

  issue_select issue_select_i (
    .alu_hold         (alu_hold),
    .mem_hold         (mem_hold),
    .alu_head_valid0  (alu_head_valid0),
    .alu_head_valid1  (alu_head_valid1),
    .alu_head_payload0(alu_head_payload0),
    .alu_head_payload1(alu_head_payload1),
    .alu_head_seq0    (alu_head_seq0),
    .alu_head_seq1    (alu_head_seq1),
    .mem_head_valid0  (mem_head_valid0),
    .mem_head_valid1  (mem_head_valid1),
    .mem_head_payload0(mem_head_payload0),
    .mem_head_payload1(mem_head_payload1),
    .mem_head_seq0    (mem_head_seq0),
    .mem_head_seq1    (mem_head_seq1),
    .alu_pop0         (alu_pop0),
    .alu_pop1         (alu_pop1),
    .mem_pop0         (mem_pop0),
    .mem_pop1         (mem_pop1),
    .issue_valid0     (issue_valid0),
    .issue_valid1     (issue_valid1),
    .issue_class0     (issue_class0),
    .issue_class1     (issue_class1),
    .issue_payload0   (issue_payload0),
    .issue_payload1   (issue_payload1),
    .issue_seq0       (issue_seq0),
    .issue_seq1       (issue_seq1)
  );

endmodule

`default_nettype wire

// File: testbench/iq_assertions.sv
`default_nettype none

module iq_assertions
  import iq_pkg::*;
#(
  parameter int DEPTH = IQ_DEPTH_DEFAULT
) (
  input wire       clk,
  input wire       rst,
  input wire       flush,
  input wire       disp_valid0,
  input wire       disp_valid1,
  input iq_class_e disp_class0,
  input iq_class_e disp_class1,
  input wire       disp_stall,
  input wire       alu_hold,
  input wire       mem_hold,
  input wire       issue_valid0,
  input wire       issue_valid1,
  input iq_class_e issue_class0,
  input iq_class_e issue_class1,
  input seq_t      issue_seq0,
  input seq_t      issue_seq1,
  input count_t    alu_free,
  input count_t    mem_free,
  input wire       alu_push0,
  input wire       alu_push1,
  input wire       mem_push0,
  input wire       mem_push1,
  input wire       alu_pop0,
  input wire       alu_pop1,
  input wire       mem_pop0,
  input wire       mem_pop1,
  input wire       alu_head_valid0,
  input wire       alu_head_valid1,
  input wire       mem_head_valid0,
  input wire       mem_head_valid1
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // read by the testbench at the end of the run

  logic [1:0] alu_need;
  logic [1:0] mem_need;
  seq_t       seq_gap;

  assign alu_need = {1'b0, disp_valid0 && disp_class0 == ALU_CLASS}
                  + {1'b0, disp_valid1 && disp_class1 == ALU_CLASS};
  assign mem_need = {1'b0, disp_valid0 && disp_class0 == MEM_CLASS}
                  + {1'b0, disp_valid1 && disp_class1 == MEM_CLASS};
  assign seq_gap  = issue_seq0 - issue_seq1;  // negative when slot 0 is the older one

  slot1_needs_slot0: assert property (@(posedge clk) disable iff (rst)
    issue_valid1 |-> issue_valid0)
    else begin
      $error("issue slot 1 is valid while slot 0 is empty");
      fail_count++;
    end

  slot0_is_older: assert property (@(posedge clk) disable iff (rst)
    issue_valid0 && issue_valid1 |-> seq_gap[SEQ_W-1])
    else begin
      $error("issue slot 0 carries a younger sequence number than slot 1");
      fail_count++;
    end

  held_class_waits: assert property (@(posedge clk) disable iff (rst)
    !(alu_hold && issue_valid0 && issue_class0 == ALU_CLASS)
    && !(alu_hold && issue_valid1 && issue_class1 == ALU_CLASS)
    && !(mem_hold && issue_valid0 && issue_class0 == MEM_CLASS)
    && !(mem_hold && issue_valid1 && issue_class1 == MEM_CLASS))
    else begin
      $error("an instruction issued to a unit that holds");
      fail_count++;
    end

  stall_matches_room: assert property (@(posedge clk) disable iff (rst)
    disp_stall == (count_t'(alu_need) > alu_free || count_t'(mem_need) > mem_free))
    else begin
      $error("dispatch stall does not match the free entries of the queues");
      fail_count++;
    end

  // second ports only with the first, pushes only into room, pops only from live heads
  queue_port_rules: assert property (@(posedge clk) disable iff (rst)
    (alu_push1 -> alu_push0) && (mem_push1 -> mem_push0)
    && (alu_push0 -> alu_free > count_t'(alu_push1))
    && (mem_push0 -> mem_free > count_t'(mem_push1))
    && (alu_pop0 -> alu_head_valid0) && (alu_pop1 -> alu_pop0 && alu_head_valid1)
    && (mem_pop0 -> mem_head_valid0) && (mem_pop1 -> mem_pop0 && mem_head_valid1))
    else begin
      $error("a queue port was driven outside its rules");
      fail_count++;
    end

  flush_empties_all: assert property (@(posedge clk)
    rst || flush |=> !issue_valid0 && !issue_valid1 && !disp_stall
                     && alu_free == DEPTH && mem_free == DEPTH)
    else begin
      $error("queues not empty in the cycle after reset or flush");
      fail_count++;
    end

endmodule

bind iq_top iq_assertions #(.DEPTH(DEPTH)) iq_assertions_i (.*);

`default_nettype wire

// File: testbench/iq_tb.sv
`default_nettype none

module iq_tb
  import iq_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [SEQ_W+PAYLOAD_W-1:0] sb_entry_t;  // {seq, payload}

  logic      clk;
  logic      rst;
  logic      flush;
  logic      disp_valid0;
  logic      disp_valid1;
  iq_class_e disp_class0;
  iq_class_e disp_class1;
  payload_t  disp_payload0;
  payload_t  disp_payload1;
  logic      disp_stall;
  logic      alu_hold;
  logic      mem_hold;
  logic      issue_valid0;
  logic      issue_valid1;
  iq_class_e issue_class0;
  iq_class_e issue_class1;
  payload_t  issue_payload0;
  payload_t  issue_payload1;
  seq_t      issue_seq0;
  seq_t      issue_seq1;

  sb_entry_t   alu_sb[$];
  sb_entry_t   mem_sb[$];
  int unsigned lcg_state = 49872;
  seq_t        model_seq;
  seq_t        next_issue_seq;
  logic        in_order_mode;  // both holds low, issue must follow dispatch order
  payload_t    next_tag;
  int          accepted_count;
  int          error_count;
  int          check_count;
  int          test_errors;
  int          test_num;

  iq_top #(.DEPTH(IQ_DEPTH_DEFAULT)) iq_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic int total_errors();
    return error_count + iq_top_i.iq_assertions_i.fail_count;
  endfunction

  task automatic record_dispatch(input iq_class_e cls, input payload_t payload);
    if (cls == ALU_CLASS) begin
      alu_sb.push_back({model_seq, payload});
    end else begin
      mem_sb.push_back({model_seq, payload});
    end
    model_seq = model_seq + 1'b1;
    accepted_count++;
  endtask

  task automatic check_issue(input int slot, input iq_class_e cls, input payload_t payload,
                             input seq_t seq);
    sb_entry_t expected;
    check_count++;
    if ((cls == ALU_CLASS && alu_sb.size() == 0) || (cls == MEM_CLASS && mem_sb.size() == 0)) begin
      $display("issue slot %0d sent %s payload %h with none of that class outstanding",
               slot, cls.name(), payload);
      error_count++;
    end else begin
      if (cls == ALU_CLASS) begin
        expected = alu_sb.pop_front();
      end else begin
        expected = mem_sb.pop_front();
      end
      if (payload !== expected[PAYLOAD_W-1:0]) begin
        $display("[FAIL] issue_payload%0d: expected %h, got %h",
                 slot, expected[PAYLOAD_W-1:0], payload);
        error_count++;
      end
      if (seq !== expected[SEQ_W+PAYLOAD_W-1:PAYLOAD_W]) begin
        $display("[FAIL] issue_seq%0d: expected %h, got %h",
                 slot, expected[SEQ_W+PAYLOAD_W-1:PAYLOAD_W], seq);
        error_count++;
      end
    end
    if (in_order_mode) begin
      if (seq !== next_issue_seq) begin
        $display("[FAIL] issue_seq%0d: expected %h, got %h", slot, next_issue_seq, seq);
        error_count++;
      end
      next_issue_seq = seq + 1'b1;
    end
  endtask

  // issues of this edge come before the dispatches that land on it
  always @(posedge clk) begin
    if (!rst && issue_valid0) begin
      check_issue(0, issue_class0, issue_payload0, issue_seq0);
    end
    if (!rst && issue_valid1) begin
      check_issue(1, issue_class1, issue_payload1, issue_seq1);
    end
    if (rst || flush) begin
      alu_sb.delete();
      mem_sb.delete();
      model_seq = '0;
    end else if (!disp_stall) begin
      if (disp_valid0) begin
        record_dispatch(disp_class0, disp_payload0);
      end
      if (disp_valid1) begin
        record_dispatch(disp_class1, disp_payload1);
      end
    end
  end

  task automatic drive_pair(input logic v0, input logic v1, input iq_class_e c0,
                            input iq_class_e c1);
    @(negedge clk);
    disp_valid0   = v0;
    disp_valid1   = v0 && v1;
    disp_class0   = c0;
    disp_class1   = c1;
    disp_payload0 = next_tag;
    disp_payload1 = next_tag + 1'b1;
    next_tag      = next_tag + 2'd2;  // every payload stays unique
  endtask

  task automatic drive_idle();
    @(negedge clk);
    disp_valid0 = 1'b0;
    disp_valid1 = 1'b0;
  endtask

  task automatic run_random(input int cycles, input logic use_holds);
    int unsigned r;
    for (int i = 0; i < cycles; i++) begin
      r = next_rand();
      drive_pair(r[0] | r[1], r[2], iq_class_e'(r[3]), iq_class_e'(r[4]));
      alu_hold = use_holds && r[7:5] < 3'd3;
      mem_hold = use_holds && r[10:8] < 3'd3;
    end
  endtask

  task automatic wait_queued(input int alu_left, input int mem_left, input int max_cycles);
    int n;
    n = 0;
    while ((alu_sb.size() != alu_left || mem_sb.size() != mem_left) && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (alu_sb.size() != alu_left || mem_sb.size() != mem_left) begin
      $display("timeout after %0d cycles with %0d ALU and %0d MEM instructions outstanding",
               max_cycles, alu_sb.size(), mem_sb.size());
      error_count++;
    end
  endtask

  task automatic expect_idle();
    @(posedge clk);
    check_count++;
    if (issue_valid0 !== 1'b0 || issue_valid1 !== 1'b0 || disp_stall !== 1'b0) begin
      $display("[FAIL] issue_valid0/issue_valid1/disp_stall: expected 0/0/0, got %h/%h/%h",
               issue_valid0, issue_valid1, disp_stall);
      error_count++;
    end
  endtask

  task automatic expect_stall(input logic level);
    @(posedge clk);
    check_count++;
    if (disp_stall !== level) begin
      $display("[FAIL] disp_stall: expected %h, got %h", level, disp_stall);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, total_errors() - test_errors);
    test_errors = total_errors();
  endtask

  task automatic hold_alu_until_full();
    int n;
    int target;
    alu_hold = 1'b1;
    mem_hold = 1'b0;
    repeat (4) drive_pair(1'b1, 1'b1, ALU_CLASS, ALU_CLASS);
    repeat (2) drive_pair(1'b1, 1'b1, MEM_CLASS, MEM_CLASS);
    drive_idle();
    wait_queued(8, 0, 50);  // memory class drains past the held ALU queue
    drive_pair(1'b1, 1'b0, ALU_CLASS, ALU_CLASS);
    repeat (3) expect_stall(1'b1);
    @(negedge clk);
    target = accepted_count + 1;
    alu_hold = 1'b0;
    n = 0;
    while (accepted_count != target && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (accepted_count != target) begin
      $display("stalled ALU instruction was not accepted after the hold dropped");
      error_count++;
    end
    drive_idle();
    wait_queued(0, 0, 50);
  endtask

  task automatic flush_and_refill();
    alu_hold = 1'b1;
    mem_hold = 1'b1;
    repeat (4) drive_pair(1'b1, 1'b1, ALU_CLASS, ALU_CLASS);  // the ALU queue is full now
    drive_pair(1'b1, 1'b1, MEM_CLASS, MEM_CLASS);
    @(negedge clk);
    flush = 1'b1;  // the last pair is still on the inputs and must be dropped
    @(negedge clk);
    flush       = 1'b0;
    disp_valid0 = 1'b0;
    disp_valid1 = 1'b0;
    alu_hold    = 1'b0;
    mem_hold    = 1'b0;
    expect_idle();
    repeat (4) drive_idle();
    drive_pair(1'b1, 1'b1, ALU_CLASS, ALU_CLASS);
    expect_stall(1'b0);
    drive_idle();
    wait_queued(0, 0, 20);
  endtask

  initial begin
    rst            = 1'b1;
    flush          = 1'b0;
    disp_valid0    = 1'b0;
    disp_valid1    = 1'b0;
    disp_class0    = ALU_CLASS;
    disp_class1    = ALU_CLASS;
    disp_payload0  = '0;
    disp_payload1  = '0;
    alu_hold       = 1'b0;
    mem_hold       = 1'b0;
    model_seq      = '0;
    next_issue_seq = '0;
    in_order_mode  = 1'b0;
    next_tag       = 16'h0100;
    accepted_count = 0;
    error_count    = 0;
    check_count    = 0;
    test_errors    = 0;
    test_num       = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    drive_idle();
    expect_idle();
    finish_test("reset state");

    run_random(400, 1'b1);
    drive_idle();
    alu_hold = 1'b0;
    mem_hold = 1'b0;
    wait_queued(0, 0, 100);
    finish_test("per-class order under random holds");

    next_issue_seq = model_seq;
    in_order_mode  = 1'b1;
    run_random(300, 1'b0);
    drive_idle();
    wait_queued(0, 0, 100);
    in_order_mode = 1'b0;
    finish_test("age priority");

    hold_alu_until_full();
    finish_test("back-pressure");

    flush_and_refill();
    finish_test("flush");

    $display("checks %0d, testbench errors %0d, assertion failures %0d",
             check_count, error_count, iq_top_i.iq_assertions_i.fail_count);
    if (total_errors() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
source/iq_pkg.sv
source/issue_queue.sv
source/dispatch_router.sv
source/issue_select.sv
source/iq_top.sv
testbench/iq_assertions.sv
testbench/iq_tb.sv
